/* build.sh */
#!/bin/sh
# compile and run the mpmem testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f project.f --top-module tb_mpmem \
  --Mdir "$OBJ" -o tb_mpmem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$OBJ/tb_mpmem" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* project.f */
+incdir+rtl
rtl/mpmem_pkg.sv
rtl/bank_req_if.sv
rtl/port_conflict_resolver.sv
rtl/mem_bank.sv
rtl/conflict_csr_wb.sv
rtl/mpmem_top.sv
sim/tb_mpmem.sv

/* rtl/bank_req_if.sv */
`default_nettype none

`include "mpmem_params.svh"

interface bank_req_if import mpmem_pkg::*; ();

  logic                  we;
  mpmem_row_t            wrow;
  logic [`MPM_WIDTH-1:0] wdata;
  logic                  re;
  mpmem_row_t            rrow;
  logic [`MPM_WIDTH-1:0] rdata; // back from the bank

  modport resolver (
    output we, wrow, wdata, re, rrow,
    input  rdata
  );

  modport bank (
    input  we, wrow, wdata, re, rrow,
    output rdata
  );

endinterface

`default_nettype wire

/* rtl/conflict_csr_wb.sv */
`default_nettype none

`include "mpmem_params.svh"

module conflict_csr_wb import mpmem_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wb_cyc,
  input  logic          wb_stb,
  input  logic          wb_we,
  input  csr_idx_t      wb_adr,
  input  logic [31:0]   wb_dat_i,
  output logic [31:0]   wb_dat_o,
  output logic          wb_ack,
  input  logic          wr_conflict,
  input  logic          rd_conflict,
  input  logic [15:0]   wr_cnt,
  input  logic [15:0]   rd_cnt,
  input  conflict_rec_t first_rec,
  output logic          clr_wr,
  output logic          clr_rd
);

  logic req;
  logic status_wr;
  logic [31:0] rd_word;

  assign req = wb_cyc && wb_stb && !wb_ack; // one access per strobe
  assign status_wr = req && wb_we && wb_adr == `MPM_REG_STATUS;

  // write one to clear
  assign clr_wr = status_wr && wb_dat_i[0];
  assign clr_rd = status_wr && wb_dat_i[1];

  always_comb begin
    case (wb_adr)
      `MPM_REG_STATUS: rd_word = {30'd0, rd_conflict, wr_conflict};
      `MPM_REG_WRCNT:  rd_word = {16'd0, wr_cnt};
      `MPM_REG_RDCNT:  rd_word = {16'd0, rd_cnt};
      default:         rd_word = 32'(first_rec);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // state as seen in the strobe cycle
  always_ff @(posedge clk) begin
    if (req && !wb_we) wb_dat_o <= rd_word;
  end

endmodule

`default_nettype wire

/* rtl/mem_bank.sv */
`default_nettype none

`include "mpmem_params.svh"

module mem_bank import mpmem_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  bank_req_if.bank req,
  output logic     init_done
);

  logic [`MPM_WIDTH-1:0] mem [`MPM_NUM_ROW];
  mpmem_row_t            clr_ptr;

  // walk every row once after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clr_ptr <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      clr_ptr <= clr_ptr + 1'b1;
      if (clr_ptr == mpmem_row_t'(`MPM_NUM_ROW - 1)) init_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!init_done) begin
      mem[clr_ptr] <= '0;
    end else if (req.we) begin
      mem[req.wrow] <= req.wdata;
    end
  end

  // same-row write in this cycle is not visible yet
  always_ff @(posedge clk) begin
    if (init_done && req.re) req.rdata <= mem[req.rrow];
  end

endmodule

`default_nettype wire

/* rtl/mpmem_params.svh */
`ifndef MPMEM_PARAMS_SVH
`define MPMEM_PARAMS_SVH

// port counts
`define MPM_NUM_WRPT 4
`define MPM_NUM_RDPT 4

// bank and row geometry
`define MPM_NUM_BANK 4
`define MPM_BIT_BANK 2
`define MPM_NUM_ROW  16
`define MPM_BIT_ROW  4

`define MPM_WIDTH    16
`define MPM_BIT_ADR  (`MPM_BIT_BANK + `MPM_BIT_ROW)

// wishbone word addresses
`define MPM_REG_STATUS 2'd0
`define MPM_REG_WRCNT  2'd1
`define MPM_REG_RDCNT  2'd2
`define MPM_REG_FIRST  2'd3

`endif

/* rtl/mpmem_pkg.sv */
`default_nettype none

`include "mpmem_params.svh"

package mpmem_pkg;

  typedef logic [`MPM_BIT_BANK-1:0] mpmem_bank_t;
  typedef logic [`MPM_BIT_ROW-1:0] mpmem_row_t;
  typedef logic [$clog2(`MPM_NUM_WRPT)-1:0] port_idx_t;

  typedef struct packed {
    mpmem_bank_t bank; // upper bits pick the bank
    mpmem_row_t  row;
  } mpmem_loc_t;

  // flat at the top ports, bank/row inside
  typedef union packed {
    logic [`MPM_BIT_ADR-1:0] word;
    mpmem_loc_t              loc;
  } mpmem_adr_u;

  typedef struct packed {
    logic        kind;   // 1 read, 0 write
    port_idx_t   winner;
    port_idx_t   loser;
    mpmem_bank_t bank;
    logic        valid;
    logic        spare;  // always 0
  } conflict_rec_t;

  typedef logic [1:0] csr_idx_t;

endpackage

`default_nettype wire

/* rtl/mpmem_top.sv */
`default_nettype none

`include "mpmem_params.svh"

module mpmem_top import mpmem_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,
  output logic                                  ready,
  input  logic [`MPM_NUM_WRPT-1:0]              write,
  input  logic [`MPM_NUM_WRPT*`MPM_BIT_ADR-1:0] wr_adr,
  input  logic [`MPM_NUM_WRPT*`MPM_WIDTH-1:0]   din,
  input  logic [`MPM_NUM_RDPT-1:0]              read,
  input  logic [`MPM_NUM_RDPT*`MPM_BIT_ADR-1:0] rd_adr,
  output logic [`MPM_NUM_RDPT*`MPM_WIDTH-1:0]   rd_dout,
  output logic [`MPM_NUM_RDPT-1:0]              rd_vld,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  logic [1:0]                            wb_adr,
  input  logic [31:0]                           wb_dat_i,
  output logic [31:0]                           wb_dat_o,
  output logic                                  wb_ack
);

  mpmem_adr_u                wr_adr_u [`MPM_NUM_WRPT];
  logic [`MPM_WIDTH-1:0]     din_a [`MPM_NUM_WRPT];
  mpmem_adr_u                rd_adr_u [`MPM_NUM_RDPT];
  logic [`MPM_NUM_RDPT-1:0]  rd_gnt, rd_gnt_q, rd_hit;
  port_idx_t                 rd_src [`MPM_NUM_BANK];
  port_idx_t                 rd_src_q [`MPM_NUM_BANK];
  mpmem_bank_t               rd_bank_q [`MPM_NUM_RDPT];
  logic [`MPM_WIDTH-1:0]     bank_rdata [`MPM_NUM_BANK];
  logic [`MPM_NUM_BANK-1:0]  init_done;
  logic                      wr_conflict, rd_conflict;
  logic                      clr_wr, clr_rd;
  logic [15:0]               wr_cnt, rd_cnt;
  conflict_rec_t             first_rec;

  bank_req_if bank_if [`MPM_NUM_BANK] ();

  for (genvar i = 0; i < `MPM_NUM_WRPT; i++) begin : g_wrpt
    assign wr_adr_u[i].word = wr_adr[i*`MPM_BIT_ADR +: `MPM_BIT_ADR];
    assign din_a[i] = din[i*`MPM_WIDTH +: `MPM_WIDTH];
  end

  for (genvar i = 0; i < `MPM_NUM_RDPT; i++) begin : g_rdpt
    assign rd_adr_u[i].word = rd_adr[i*`MPM_BIT_ADR +: `MPM_BIT_ADR];
  end

  port_conflict_resolver u_resolver (
    .clk, .rst_n, .ready, .write,
    .wr_adr(wr_adr_u), .din(din_a), .read, .rd_adr(rd_adr_u),
    .bank(bank_if), .rd_gnt, .rd_src,
    .wr_conflict, .rd_conflict, .wr_cnt, .rd_cnt, .first_rec,
    .clr_wr, .clr_rd
  );

  for (genvar b = 0; b < `MPM_NUM_BANK; b++) begin : g_bank
    mem_bank u_bank (
      .clk, .rst_n,
      .req(bank_if[b]),
      .init_done(init_done[b])
    );
    assign bank_rdata[b] = bank_if[b].rdata;
  end

  assign ready = &init_done;

  conflict_csr_wb u_csr (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we,
    .wb_adr(csr_idx_t'(wb_adr)), .wb_dat_i, .wb_dat_o, .wb_ack,
    .wr_conflict, .rd_conflict, .wr_cnt, .rd_cnt, .first_rec,
    .clr_wr, .clr_rd
  );

  always_ff @(posedge clk) begin
    if (!rst_n) rd_gnt_q <= '0;
    else rd_gnt_q <= rd_gnt;
  end

  // routing follows the bank read by one cycle
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MPM_NUM_RDPT; p++) rd_bank_q[p] <= rd_adr_u[p].loc.bank;
    for (int b = 0; b < `MPM_NUM_BANK; b++) rd_src_q[b] <= rd_src[b];
  end

  always_comb begin
    for (int p = 0; p < `MPM_NUM_RDPT; p++) begin
      rd_hit[p] = rd_gnt_q[p] && rd_src_q[rd_bank_q[p]] == port_idx_t'(p);
      rd_vld[p] = rd_hit[p];
      rd_dout[p*`MPM_WIDTH +: `MPM_WIDTH] = rd_hit[p] ? bank_rdata[rd_bank_q[p]] : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/port_conflict_resolver.sv */
`default_nettype none

`include "mpmem_params.svh"

module port_conflict_resolver import mpmem_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ready,
  input  logic [`MPM_NUM_WRPT-1:0] write,
  input  mpmem_adr_u              wr_adr [`MPM_NUM_WRPT],
  input  logic [`MPM_WIDTH-1:0]   din [`MPM_NUM_WRPT],
  input  logic [`MPM_NUM_RDPT-1:0] read,
  input  mpmem_adr_u              rd_adr [`MPM_NUM_RDPT],
  bank_req_if.resolver            bank [`MPM_NUM_BANK],
  output logic [`MPM_NUM_RDPT-1:0] rd_gnt,
  output port_idx_t               rd_src [`MPM_NUM_BANK],
  output logic                    wr_conflict,
  output logic                    rd_conflict,
  output logic [15:0]             wr_cnt,
  output logic [15:0]             rd_cnt,
  output conflict_rec_t           first_rec,
  input  logic                    clr_wr,
  input  logic                    clr_rd
);

  port_idx_t                wr_win [`MPM_NUM_BANK];
  port_idx_t                wr_lose [`MPM_NUM_BANK];
  port_idx_t                rd_win [`MPM_NUM_BANK];
  port_idx_t                rd_lose [`MPM_NUM_BANK];
  logic [`MPM_NUM_BANK-1:0] wr_any, wr_multi;
  logic [`MPM_NUM_BANK-1:0] rd_any, rd_multi;
  logic                     wr_ev, rd_ev;
  logic                     wr_left, rd_left;
  logic                     rec_armed;
  conflict_rec_t            rec_next;

  // lowest active port wins, second lowest is the reported loser
  always_comb begin
    for (int b = 0; b < `MPM_NUM_BANK; b++) begin
      wr_any[b] = 1'b0;
      wr_multi[b] = 1'b0;
      wr_win[b] = '0;
      wr_lose[b] = '0;
      for (int i = 0; i < `MPM_NUM_WRPT; i++) begin
        if (ready && write[i] && wr_adr[i].loc.bank == mpmem_bank_t'(b)) begin
          if (!wr_any[b]) begin
            wr_any[b] = 1'b1;
            wr_win[b] = port_idx_t'(i);
          end else if (!wr_multi[b]) begin
            wr_multi[b] = 1'b1;
            wr_lose[b] = port_idx_t'(i);
          end
        end
      end
      rd_any[b] = 1'b0;
      rd_multi[b] = 1'b0;
      rd_win[b] = '0;
      rd_lose[b] = '0;
      for (int i = 0; i < `MPM_NUM_RDPT; i++) begin
        if (ready && read[i] && rd_adr[i].loc.bank == mpmem_bank_t'(b)) begin
          if (!rd_any[b]) begin
            rd_any[b] = 1'b1;
            rd_win[b] = port_idx_t'(i);
          end else if (!rd_multi[b]) begin
            rd_multi[b] = 1'b1;
            rd_lose[b] = port_idx_t'(i);
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `MPM_NUM_RDPT; i++) begin
      rd_gnt[i] = ready && read[i] && rd_win[rd_adr[i].loc.bank] == port_idx_t'(i);
    end
  end

  for (genvar g = 0; g < `MPM_NUM_BANK; g++) begin : g_bank
    assign bank[g].we    = wr_any[g];
    assign bank[g].wrow  = wr_adr[wr_win[g]].loc.row;
    assign bank[g].wdata = din[wr_win[g]];
    assign bank[g].re    = rd_any[g];
    assign bank[g].rrow  = rd_adr[rd_win[g]].loc.row;
    assign rd_src[g]     = rd_win[g];
  end

  assign wr_ev = |wr_multi;
  assign rd_ev = |rd_multi;

  // write side takes precedence, lowest bank first
  always_comb begin
    rec_next = '0;
    rec_next.valid = 1'b1;
    rec_next.kind = !wr_ev;
    for (int b = `MPM_NUM_BANK - 1; b >= 0; b--) begin
      if (wr_ev ? wr_multi[b] : rd_multi[b]) begin
        rec_next.bank = mpmem_bank_t'(b);
        rec_next.winner = wr_ev ? wr_win[b] : rd_win[b];
        rec_next.loser = wr_ev ? wr_lose[b] : rd_lose[b];
      end
    end
  end

  assign wr_left = wr_conflict && !clr_wr;
  assign rd_left = rd_conflict && !clr_rd;
  assign rec_armed = !first_rec.valid || (!wr_left && !rd_left);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_conflict <= 1'b0;
      rd_conflict <= 1'b0;
      wr_cnt <= '0;
      rd_cnt <= '0;
      first_rec <= '0;
    end else begin
      wr_conflict <= wr_left || wr_ev;
      rd_conflict <= rd_left || rd_ev;
      if (clr_wr) wr_cnt <= {15'd0, wr_ev};
      else if (wr_ev && wr_cnt != 16'hffff) wr_cnt <= wr_cnt + 16'd1;
      if (clr_rd) rd_cnt <= {15'd0, rd_ev};
      else if (rd_ev && rd_cnt != 16'hffff) rd_cnt <= rd_cnt + 16'd1;
      if (rec_armed) first_rec <= (wr_ev || rd_ev) ? rec_next : '0;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_mpmem.sv */
`default_nettype none

`include "mpmem_params.svh"

module tb_mpmem import mpmem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [`MPM_NUM_RDPT*`MPM_WIDTH-1:0] dout;
    logic [`MPM_NUM_RDPT-1:0]            vld;
    logic                                wr_inc;
    logic                                rd_inc;
    conflict_rec_t                       rec;
  } exp_t;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  ready;
  logic [`MPM_NUM_WRPT-1:0]              write;
  logic [`MPM_NUM_WRPT*`MPM_BIT_ADR-1:0] wr_adr;
  logic [`MPM_NUM_WRPT*`MPM_WIDTH-1:0]   din;
  logic [`MPM_NUM_RDPT-1:0]              read;
  logic [`MPM_NUM_RDPT*`MPM_BIT_ADR-1:0] rd_adr;
  logic [`MPM_NUM_RDPT*`MPM_WIDTH-1:0]   rd_dout;
  logic [`MPM_NUM_RDPT-1:0]              rd_vld;
  logic                                  wb_cyc, wb_stb, wb_we, wb_ack;
  logic [1:0]                            wb_adr;
  logic [31:0]                           wb_dat_i, wb_dat_o;

  logic [`MPM_WIDTH-1:0] shadow [64]; // indexed by {bank, row}
  exp_t                  exp_q [$];
  exp_t                  cmp_e;
  logic [15:0]           exp_wr_cnt, exp_rd_cnt;
  conflict_rec_t         exp_rec;
  int                    errors = 0;
  int                    checks = 0;
  int                    test_base = 0;
  int                    tests_run = 0;
  int                    tests_bad = 0;

  mpmem_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_data(input string name, input logic [`MPM_WIDTH-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_vld(input string name, input logic [`MPM_NUM_RDPT-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input logic [15:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input logic [1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_rec(input string name, input conflict_rec_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic abort(input string why);
    $display("%s", why);
    $display("tests failed");
    $finish;
  endtask

  // lowest and second lowest active port on one bank, -1 if none
  function automatic void find_pair(input logic [3:0] en, input logic [23:0] adr,
                                    input int bk, output int win, output int lose);
    win = -1;
    lose = -1;
    for (int p = 0; p < 4; p++) begin
      if (en[p] && int'(adr[p*6+4 +: 2]) == bk) begin
        if (win < 0) win = p;
        else if (lose < 0) lose = p;
      end
    end
  endfunction

  function automatic conflict_rec_t make_rec(input logic kind, input int win, input int lose,
                                             input int bk);
    conflict_rec_t rec;
    rec = '0;
    rec.kind = kind;
    rec.winner = port_idx_t'(win);
    rec.loser = port_idx_t'(lose);
    rec.bank = mpmem_bank_t'(bk);
    rec.valid = 1'b1;
    return rec;
  endfunction

  function automatic exp_t ref_model(input logic [3:0] w, input logic [23:0] wa,
                                     input logic [63:0] d, input logic [3:0] r,
                                     input logic [23:0] ra);
    exp_t          e;
    conflict_rec_t wrec, rrec;
    int            win, lose;
    e = '0;
    wrec = '0;
    rrec = '0;
    // reads see the memory before this cycle's writes
    for (int b = 0; b < 4; b++) begin
      find_pair(r, ra, b, win, lose);
      if (win >= 0) begin
        e.vld[win] = 1'b1;
        e.dout[win*16 +: 16] = shadow[ra[win*6 +: 6]];
      end
      if (lose >= 0) begin
        e.rd_inc = 1'b1;
        if (!rrec.valid) rrec = make_rec(1'b1, win, lose, b);
      end
    end
    for (int b = 0; b < 4; b++) begin
      find_pair(w, wa, b, win, lose);
      if (win >= 0) shadow[wa[win*6 +: 6]] = d[win*16 +: 16];
      if (lose >= 0) begin
        e.wr_inc = 1'b1;
        if (!wrec.valid) wrec = make_rec(1'b0, win, lose, b);
      end
    end
    e.rec = e.wr_inc ? wrec : rrec; // write conflict wins the record
    return e;
  endfunction

  task automatic mem_cycle(input logic [3:0] w, input logic [23:0] wa, input logic [63:0] d,
                           input logic [3:0] r, input logic [23:0] ra);
    exp_t e;
    @(negedge clk);
    write = w;
    wr_adr = wa;
    din = d;
    read = r;
    rd_adr = ra;
    e = '0;
    if (ready) begin
      e = ref_model(w, wa, d, r, ra);
      if (e.wr_inc && exp_wr_cnt != 16'hffff) exp_wr_cnt++;
      if (e.rd_inc && exp_rd_cnt != 16'hffff) exp_rd_cnt++;
      if (!exp_rec.valid) exp_rec = e.rec;
    end
    exp_q.push_back(e);
  endtask

  task automatic go_idle();
    @(negedge clk);
    write = '0;
    read = '0;
  endtask

  // outputs settle after the edge, compare a quarter period later
  always begin
    @(posedge clk);
    #5;
    while (exp_q.size() > 0) begin
      cmp_e = exp_q.pop_front();
      check_vld("rd_vld", rd_vld, cmp_e.vld);
      for (int p = 0; p < 4; p++) begin
        check_data($sformatf("rd_dout[%0d]", p), rd_dout[p*16 +: 16], cmp_e.dout[p*16 +: 16]);
      end
    end
  end

  task automatic wb_access(input csr_idx_t adr, input logic we, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(negedge clk);
    write = '0;
    read = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_i = wdat;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < 16);
    if (!wb_ack) abort("no wishbone ack within 16 cycles");
    rdat = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_read(input csr_idx_t adr, output logic [31:0] data);
    wb_access(adr, 1'b0, '0, data);
  endtask

  task automatic wb_write(input csr_idx_t adr, input logic [31:0] data);
    logic [31:0] ignored;
    wb_access(adr, 1'b1, data, ignored);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!ready) abort("ready did not rise within 100 cycles");
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    write = '0;
    read = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 64; i++) shadow[i] = '0;
    exp_wr_cnt = '0;
    exp_rd_cnt = '0;
    exp_rec = '0;
  endtask

  // every port hits every bank, no two ports on one bank
  task automatic sweep_read();
    logic [23:0] ra;
    for (int r = 0; r < 16; r++) begin
      for (int p = 0; p < 4; p++) ra[p*6 +: 6] = {2'((p + r) % 4), 4'(r)};
      mem_cycle('0, '0, '0, 4'hf, ra);
    end
    go_idle();
  endtask

  task automatic check_csr();
    logic [31:0] word;
    wb_read(`MPM_REG_STATUS, word);
    check_flags("status", word[1:0], {|exp_rd_cnt, |exp_wr_cnt});
    wb_read(`MPM_REG_WRCNT, word);
    check_cnt("wr_cnt", word[15:0], exp_wr_cnt);
    wb_read(`MPM_REG_RDCNT, word);
    check_cnt("rd_cnt", word[15:0], exp_rd_cnt);
    wb_read(`MPM_REG_FIRST, word);
    check_rec("first_rec", conflict_rec_t'(word[8:0]), exp_rec);
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (errors != test_base) tests_bad++;
    $display("test %0d %s: %0d errors", num, name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    logic [23:0] wa, ra;
    logic [63:0] d;
    void'($urandom(32'he2e3c034));
    rst_n = 1'b0;
    write = '0;
    wr_adr = '0;
    din = '0;
    read = '0;
    rd_adr = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_i = '0;

    apply_reset();
    wait_ready();
    sweep_read();
    end_test(1, "reset clears memory");

    for (int k = 0; k < 8; k++) begin
      for (int p = 0; p < 4; p++) begin
        wa[p*6 +: 6] = {2'((p + k) % 4), 4'($urandom_range(15))};
        d[p*16 +: 16] = 16'($urandom);
      end
      for (int p = 0; p < 4; p++) ra[p*6 +: 6] = wa[((p + 1) % 4)*6 +: 6];
      mem_cycle(4'hf, wa, d, '0, '0);
      mem_cycle('0, '0, '0, 4'hf, ra);
    end
    go_idle();
    end_test(2, "write then read distinct banks");

    for (int k = 0; k < 300; k++) begin
      for (int p = 0; p < 4; p++) begin
        wa[p*6 +: 6] = 6'($urandom);
        ra[p*6 +: 6] = 6'($urandom);
        d[p*16 +: 16] = 16'($urandom);
      end
      mem_cycle(4'($urandom), wa, d, 4'($urandom), ra);
    end
    go_idle();
    sweep_read();
    end_test(3, "random colliding traffic");

    check_csr();
    end_test(4, "conflict counters");

    wb_write(`MPM_REG_STATUS, 32'h1);
    exp_wr_cnt = '0;
    if (exp_rd_cnt == '0) exp_rec = '0;
    check_csr();
    wb_write(`MPM_REG_STATUS, 32'h2);
    exp_rd_cnt = '0;
    exp_rec = '0;
    check_csr();
    ra = '0;
    ra[1*6 +: 6] = 6'h25; // ports 1 and 3 on bank 2
    ra[3*6 +: 6] = 6'h2a;
    mem_cycle('0, '0, '0, 4'b1010, ra);
    go_idle();
    check_csr();
    end_test(5, "first record and clear");

    apply_reset();
    for (int k = 0; k < 6; k++) begin
      // row k is already behind the clear walk, two ports per bank
      for (int p = 0; p < 4; p++) wa[p*6 +: 6] = {2'(p / 2), 4'(k)};
      mem_cycle(4'hf, wa, {4{16'hbeef}}, 4'hf, wa);
      if (ready) begin
        errors++;
        $display("ready was high right after reset");
      end
    end
    go_idle();
    wait_ready();
    check_csr();
    sweep_read();
    end_test(6, "requests ignored before ready");

    repeat (2) @(negedge clk);
    $display("tests %0d, failing %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
